//--- framebuffer.f
+incdir+hdl
hdl/fb_pkg.sv
hdl/scan_if.sv
hdl/video_timing.sv
hdl/buffer_arbiter.sv
hdl/frame_store.sv
hdl/video_output.sv
hdl/framebuffer.sv
tb/tb_framebuffer.sv

//--- Makefile
TOP = tb_framebuffer

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f framebuffer.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

lint:
	verilator --lint-only --timing --assert -f framebuffer.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- tb/tb_framebuffer.sv
/*
 * Directed testbench for the framebuffer
 *   Clock, reset and source frame writer
 *   Reset, sync geometry and scan-out checkers
 *   Double buffer, tearing, rotation and single buffer tests
 */
module tb_framebuffer;
    import fb_pkg::*;

    localparam int H_TOTAL  = 800;             // 640x480@60 modeline
    localparam int H_ACTIVE = 640;
    localparam int H_SYNC_W = 96;
    localparam int V_TOTAL  = 525;
    localparam int V_ACTIVE = 480;
    localparam int V_SYNC_W = 2;
    localparam int SRC_W    = 320;
    localparam int SRC_H    = 240;
    localparam int SCALE    = 2;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam logic [7:0] TAG_A = 8'h3c;
    localparam logic [7:0] TAG_B = 8'hc5;

    logic    clk_vga = 1'b0;
    logic    rst_n;
    src_x_t  src_x;
    src_y_t  src_y;
    pixel_t  rgb_in;
    logic    pixel_valid;
    logic    vblank_in;
    rotate_t rotate;
    logic    disable_db;
    pixel_t  rgb_out;
    logic    hsync_out;
    logic    vsync_out;
    logic    blank_out;
    int      seed;

    always #2 clk_vga = ~clk_vga;              // Period 4

    framebuffer i_framebuffer (
        .clk_vga     (clk_vga),
        .rst_n       (rst_n),
        .x           (src_x),
        .y           (src_y),
        .rgb_in      (rgb_in),
        .pixel_valid (pixel_valid),
        .vblank_in   (vblank_in),
        .rotate      (rotate),
        .disable_db  (disable_db),
        .rgb_out     (rgb_out),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .blank_out   (blank_out)
    );

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic compare_values(input string what, input logic [31:0] got,
                                  input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s, got %0d, expected %0d", $time, what, got, expected);
            abort_run();
        end
    endtask

    // Colour from the full linear address plus a frame tag
    function automatic pixel_t pattern(input int sx, input int sy, input logic [7:0] tag);
        int a;
        a = sy * SRC_W + sx;
        return pixel_t'((a ^ (a >> 8) ^ (a >> 16)) + int'(tag));
    endfunction

    task automatic set_vblank(input logic level);
        @(posedge clk_vga);
        vblank_in <= level;
    endtask

    task automatic write_rows(input logic [7:0] tag, input int row_first, input int row_last);
        int row;
        int col;
        for (row = row_first; row <= row_last; row++) begin
            for (col = 0; col < SRC_W; col++) begin
                @(posedge clk_vga);
                src_x       <= src_x_t'(col);
                src_y       <= src_y_t'(row);
                rgb_in      <= pattern(col, row, tag);
                pixel_valid <= 1'b1;      // One strobe per pixel
            end
        end
        @(posedge clk_vga);
        pixel_valid <= 1'b0;
    endtask

    task automatic write_frame(input logic [7:0] tag);
        set_vblank(1'b0);                     // Source frame starts
        write_rows(tag, 0, SRC_H - 1);
        set_vblank(1'b1);                     // Source frame complete
    endtask

    // Returns on the first sample with vsync_out low
    task automatic wait_vsync_fall();
        int   n;
        logic prev;
        n = 0;
        @(negedge clk_vga);
        prev = vsync_out;
        @(negedge clk_vga);
        while (!(prev && !vsync_out)) begin
            prev = vsync_out;
            @(negedge clk_vga);
            n++;
            if (n > 2 * FRAME_CYCLES) begin
                $display("Timed out waiting for a falling edge of vsync_out");
                abort_run();
            end
        end
    endtask

    task automatic wait_active_line();
        int n;
        n = 0;
        while (blank_out !== 1'b0) begin
            @(negedge clk_vga);
            n++;
            if (n > 50 * H_TOTAL) begin
                $display("Timed out waiting for an active line on blank_out");
                abort_run();
            end
        end
    endtask

    task automatic check_idle_outputs(input string when);
        compare_values({"hsync_out ", when}, 32'(hsync_out), 1);
        compare_values({"vsync_out ", when}, 32'(vsync_out), 1);
        compare_values({"blank_out ", when}, 32'(blank_out), 1);
        compare_values({"rgb_out ", when}, 32'(rgb_out), 0);
    endtask

    // Walks one output frame, column c and row r show source (c/2, r/2)
    task automatic check_frame(input logic [7:0] tag, input logic rot180, input string name);
        int    row;
        int    col;
        int    sx;
        int    sy;
        string what;
        wait_vsync_fall();
        for (row = 0; row < V_ACTIVE; row++) begin
            wait_active_line();
            what = $sformatf("%s row %0d", name, row);
            for (col = 0; col < H_ACTIVE; col++) begin
                sx = col / SCALE;
                sy = row / SCALE;
                if (rot180) begin
                    sx = SRC_W - 1 - sx;      // Mirrored both ways
                    sy = SRC_H - 1 - sy;
                end
                compare_values(what, 32'(rgb_out), 32'(pattern(sx, sy, tag)));
                @(negedge clk_vga);
            end
            compare_values({what, " blank after 640 pixels"}, 32'(blank_out), 1);
        end
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic check_reset_state();
        int i;
        for (i = 0; i < 10; i++) begin
            @(negedge clk_vga);
            check_idle_outputs("in reset");
        end
        @(posedge clk_vga);
        rst_n <= 1'b1;
        @(negedge clk_vga);
        check_idle_outputs("after reset");
    endtask

    task automatic check_sync_geometry();
        int   i;
        int   hs_low;
        int   bl_low;
        int   vs_low;
        int   hs_falls;
        int   act_lines;
        int   hs_run;
        int   bl_run;
        int   since_fall;
        logic hs_prev;
        logic bl_prev;
        logic vs_prev;
        hs_low     = 0;
        bl_low     = 0;
        vs_low     = 0;
        hs_falls   = 0;
        act_lines  = 0;
        hs_run     = 0;
        bl_run     = 0;
        since_fall = 0;
        wait_vsync_fall();                    // Line 490, column 0
        hs_prev = 1'b1;
        bl_prev = 1'b1;
        vs_prev = 1'b1;
        for (i = 0; i < FRAME_CYCLES; i++) begin
            since_fall++;
            if (hs_prev && !hsync_out) begin
                if (hs_falls > 0)
                    compare_values("line length", since_fall, H_TOTAL);
                since_fall = 0;
                hs_falls++;
            end
            if (!hsync_out) begin
                hs_low++;
                hs_run++;
            end else if (!hs_prev) begin
                compare_values("hsync pulse width", hs_run, H_SYNC_W);
                hs_run = 0;
            end
            if (!blank_out) begin
                bl_low++;
                bl_run++;
                if (bl_prev)
                    act_lines++;              // New active line
            end else begin
                compare_values("rgb_out during blank", 32'(rgb_out), 0);
                if (!bl_prev)
                    compare_values("active pixels per line", bl_run, H_ACTIVE);
                bl_run = 0;
            end
            if (!vsync_out)
                vs_low++;
            hs_prev = hsync_out;
            bl_prev = blank_out;
            vs_prev = vsync_out;
            @(negedge clk_vga);
        end
        // Next frame starts exactly 525 lines later
        compare_values("vsync_out after one frame", 32'(vsync_out), 0);
        compare_values("vsync_out before frame end", 32'(vs_prev), 1);
        compare_values("hsync pulses per frame", hs_falls, V_TOTAL);
        compare_values("hsync low cycles", hs_low, H_SYNC_W * V_TOTAL);
        compare_values("active lines", act_lines, V_ACTIVE);
        compare_values("active cycles", bl_low, H_ACTIVE * V_ACTIVE);
        compare_values("vsync low cycles", vs_low, V_SYNC_W * H_TOTAL);
    endtask

    task automatic test_double_buffer();
        write_frame(TAG_A);
        check_frame(TAG_A, 1'b0, "frame A");
    endtask

    task automatic test_no_tearing();
        set_vblank(1'b0);
        write_rows(TAG_B, 0, SRC_H / 2 - 1);  // Half of B, source still in frame
        check_frame(TAG_A, 1'b0, "frame A during write of B");
        write_rows(TAG_B, SRC_H / 2, SRC_H - 1);
        set_vblank(1'b1);
        check_frame(TAG_B, 1'b0, "frame B");
    endtask

    task automatic test_rotate_180();
        @(posedge clk_vga);
        rotate <= ROT_180;
        check_frame(TAG_B, 1'b1, "frame B rotated");
    endtask

    task automatic test_single_buffer();
        logic [7:0] tag_c;
        tag_c = 8'($random(seed));
        if (tag_c == TAG_B)
            tag_c = ~tag_c;                   // Must differ from the old frame
        @(posedge clk_vga);
        rotate     <= ROT_0;
        disable_db <= 1'b1;
        write_frame(tag_c);
        check_frame(tag_c, 1'b0, "frame C single buffer");
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        seed        = 32'hf7ea;
        rst_n       = 1'b0;
        src_x       = '0;
        src_y       = '0;
        rgb_in      = '0;
        pixel_valid = 1'b0;
        vblank_in   = 1'b1;                   // Source idles between frames
        rotate      = ROT_0;
        disable_db  = 1'b0;

        $display("Reset state");
        check_reset_state();
        $display("Sync geometry");
        check_sync_geometry();
        $display("Double buffering");
        test_double_buffer();
        $display("No tearing");
        test_no_tearing();
        $display("Rotation 180");
        test_rotate_180();
        $display("Single buffer");
        test_single_buffer();

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- hdl/framebuffer.sv
/*
 * Framebuffer top level
 * 320x240 source into two frame memories
 * 640x480@60 VGA out at 2x scale
 */
module framebuffer (
    input  logic            clk_vga,
    input  logic            rst_n,
    // Source pixels
    input  fb_pkg::src_x_t  x,
    input  fb_pkg::src_y_t  y,
    input  fb_pkg::pixel_t  rgb_in,
    input  logic            pixel_valid,
    input  logic            vblank_in,
    // Control
    input  fb_pkg::rotate_t rotate,
    input  logic            disable_db,
    // VGA
    output fb_pkg::pixel_t  rgb_out,
    output logic            hsync_out,
    output logic            vsync_out,
    output logic            blank_out
);
    import fb_pkg::*;

    scan_if   scan ();           // Beam position and sync levels
    logic     frame_end;
    buf_sel_t wr_sel;
    logic     wr_enable;
    buf_sel_t show_sel;
    pixel_t   rd_data;

    video_timing i_video_timing (
        .clk_vga   (clk_vga),
        .rst_n     (rst_n),
        .scan      (scan),
        .frame_end (frame_end)
    );

    buffer_arbiter i_buffer_arbiter (
        .clk_vga    (clk_vga),
        .rst_n      (rst_n),
        .vblank_in  (vblank_in),
        .disable_db (disable_db),
        .frame_end  (frame_end),
        .wr_sel     (wr_sel),
        .wr_enable  (wr_enable),
        .show_sel   (show_sel)
    );

    frame_store i_frame_store (
        .clk_vga     (clk_vga),
        .x           (x),
        .y           (y),
        .rgb_in      (rgb_in),
        .pixel_valid (pixel_valid),
        .wr_sel      (wr_sel),
        .wr_enable   (wr_enable),
        .show_sel    (show_sel),
        .rotate      (rotate),
        .scan        (scan),
        .rd_data     (rd_data)
    );

    video_output i_video_output (
        .clk_vga   (clk_vga),
        .rst_n     (rst_n),
        .scan      (scan),
        .rd_data   (rd_data),
        .rgb_out   (rgb_out),
        .hsync_out (hsync_out),
        .vsync_out (vsync_out),
        .blank_out (blank_out)
    );

endmodule

//--- hdl/video_output.sv
/*
 * VGA output stage
 * Sync and blank delayed to line up with read data
 * Registered outputs with black during blank
 */
`include "fb_consts.svh"

module video_output (
    input  logic           clk_vga,
    input  logic           rst_n,
    scan_if.sink           scan,
    input  fb_pkg::pixel_t rd_data,
    output fb_pkg::pixel_t rgb_out,
    output logic           hsync_out,
    output logic           vsync_out,
    output logic           blank_out
);
    localparam int LAT = `FB_RD_LATENCY;

    // Delay lines, last stage is the output register
    logic [LAT-1:0] hs_dly;
    logic [LAT-1:0] vs_dly;
    logic [LAT-1:0] bl_dly;

    always_ff @(posedge clk_vga or negedge rst_n) begin
        if (!rst_n) begin
            hs_dly  <= '1;             // Sync idles high
            vs_dly  <= '1;
            bl_dly  <= '1;
            rgb_out <= '0;
        end else begin
            hs_dly <= {hs_dly[LAT-2:0], scan.hsync};
            vs_dly <= {vs_dly[LAT-2:0], scan.vsync};
            bl_dly <= {bl_dly[LAT-2:0], scan.blank};
            // Stage LAT-2 blank matches the data now at rd_data
            rgb_out <= bl_dly[LAT-2] ? '0 : rd_data;
        end
    end

    assign hsync_out = hs_dly[LAT-1];
    assign vsync_out = vs_dly[LAT-1];
    assign blank_out = bl_dly[LAT-1];

endmodule

//--- hdl/frame_store.sv
/*
 * Two frame memories of 320x240 pixels
 *   Write port with address from the source x and y
 *   Registered read address with 0 or 180 degree rotation
 *   Read data of the displayed buffer
 */
`include "fb_consts.svh"

module frame_store (
    input  logic             clk_vga,
    input  fb_pkg::src_x_t   x,
    input  fb_pkg::src_y_t   y,
    input  fb_pkg::pixel_t   rgb_in,
    input  logic             pixel_valid,
    input  fb_pkg::buf_sel_t wr_sel,
    input  logic             wr_enable,
    input  fb_pkg::buf_sel_t show_sel,
    input  fb_pkg::rotate_t  rotate,
    scan_if.sink             scan,
    output fb_pkg::pixel_t   rd_data
);
    import fb_pkg::*;

    localparam int WORDS = `FB_SRC_W * `FB_SRC_H;

    pixel_t   mem0 [WORDS];          // Buffer 0
    pixel_t   mem1 [WORDS];          // Buffer 1
    fb_addr_t wr_addr;
    logic     wr_ok;
    src_x_t   rd_col;                // Column after rotation
    src_y_t   rd_row;                // Row after rotation
    fb_addr_t rd_addr_d;
    fb_addr_t rd_addr;
    pixel_t   q0;
    pixel_t   q1;

    // -----------------------------------------------------------------
    // Write side
    // -----------------------------------------------------------------
    assign wr_addr = fb_addr_t'(y) * fb_addr_t'(`FB_SRC_W) + fb_addr_t'(x);

    // Positions outside the source image are dropped
    assign wr_ok = pixel_valid && wr_enable &&
                   (x < src_x_t'(`FB_SRC_W)) && (y < src_y_t'(`FB_SRC_H));

    always_ff @(posedge clk_vga) begin
        if (wr_ok && (wr_sel == 1'b0))
            mem0[wr_addr] <= rgb_in;
    end

    always_ff @(posedge clk_vga) begin
        if (wr_ok && (wr_sel == 1'b1))
            mem1[wr_addr] <= rgb_in;
    end

    // -----------------------------------------------------------------
    // Read side
    // -----------------------------------------------------------------
    always_comb begin
        if (rotate == ROT_180) begin
            rd_col = src_x_t'(`FB_SRC_W - 1) - scan.win_x;   // Mirror both axes
            rd_row = src_y_t'(`FB_SRC_H - 1) - scan.win_y;
        end else begin
            rd_col = scan.win_x;
            rd_row = scan.win_y;
        end
        rd_addr_d = fb_addr_t'(rd_row) * fb_addr_t'(`FB_SRC_W) + fb_addr_t'(rd_col);
    end

    always_ff @(posedge clk_vga) begin
        rd_addr <= rd_addr_d;
    end

    // Both memories read every cycle, screen buffer picked after
    assign q0      = mem0[rd_addr];
    assign q1      = mem1[rd_addr];
    assign rd_data = show_sel ? q1 : q0;

endmodule

//--- hdl/buffer_arbiter.sv
/*
 * Double buffer state machine
 * One state per buffer, swap only at the end of an output frame
 * Single buffer mode writes straight into the displayed buffer
 */
module buffer_arbiter (
    input  logic             clk_vga,
    input  logic             rst_n,
    input  logic             vblank_in,
    input  logic             disable_db,
    input  logic             frame_end,
    output fb_pkg::buf_sel_t wr_sel,
    output logic             wr_enable,
    output fb_pkg::buf_sel_t show_sel
);
    import fb_pkg::*;

    buf_state_t state_q [2];
    buf_state_t state_d [2];
    logic       vblank_q;
    logic       vblank_rise;         // Source frame complete
    logic       vblank_fall;         // Source frame starting
    buf_sel_t   spare;               // The buffer not on screen

    assign vblank_rise = vblank_in && !vblank_q;
    assign vblank_fall = !vblank_in && vblank_q;

    assign show_sel = buf_sel_t'(state_q[1] == BUF_SHOWING);
    assign spare    = ~show_sel;

    // Single buffer mode targets the screen buffer directly
    assign wr_sel    = disable_db ? show_sel : spare;
    assign wr_enable = disable_db || (state_q[spare] == BUF_WRITING);

    always_comb begin
        state_d = state_q;
        if (disable_db) begin
            state_d[spare] = BUF_FREE;            // Spare idles, no swaps
        end else begin
            if (vblank_rise && (state_q[spare] == BUF_WRITING))
                state_d[spare] = BUF_READY;
            if (vblank_fall && (state_q[spare] == BUF_FREE))
                state_d[spare] = BUF_WRITING;
            // Swap only between output frames so the picture never tears
            if (frame_end && (state_d[spare] == BUF_READY)) begin
                state_d[spare]    = BUF_SHOWING;
                state_d[show_sel] = BUF_FREE;
            end
        end
    end

    always_ff @(posedge clk_vga or negedge rst_n) begin
        if (!rst_n) begin
            state_q[0] <= BUF_SHOWING;
            state_q[1] <= BUF_FREE;
            vblank_q   <= 1'b1;        // First low level counts as a frame start
        end else begin
            state_q  <= state_d;
            vblank_q <= vblank_in;
        end
    end

    a_one_showing: assert property (@(posedge clk_vga) disable iff (!rst_n)
        (state_q[0] == BUF_SHOWING) != (state_q[1] == BUF_SHOWING));

    a_one_writing: assert property (@(posedge clk_vga) disable iff (!rst_n)
        !((state_q[0] == BUF_WRITING) && (state_q[1] == BUF_WRITING)));

endmodule

//--- hdl/video_timing.sv
/*
 * VGA timing generator
 *   800x525 pixel and line counters
 *   Scale counters and source window coordinates
 *   Registered sync, blank and frame end pulse
 */
`include "fb_consts.svh"

module video_timing (
    input  logic   clk_vga,
    input  logic   rst_n,
    scan_if.source scan,
    output logic   frame_end
);
    import fb_pkg::*;

    localparam int SUB_W = $clog2(`FB_SCALE);
    localparam logic [SUB_W-1:0] SUB_LAST = SUB_W'(`FB_SCALE - 1);

    scan_cnt_t        h_cnt;       // Pixel within line
    scan_cnt_t        v_cnt;       // Line within frame
    logic [SUB_W-1:0] h_sub;       // Output pixel within source pixel
    logic [SUB_W-1:0] v_sub;       // Output line within source line
    src_x_t           win_x_cnt;
    src_y_t           win_y_cnt;
    logic             line_end;
    logic             frame_last;

    assign line_end   = (h_cnt == scan_cnt_t'(`FB_H_TOTAL - 1));
    assign frame_last = line_end && (v_cnt == scan_cnt_t'(`FB_V_TOTAL - 1));

    // -----------------------------------------------------------------
    // Counters
    // -----------------------------------------------------------------
    always_ff @(posedge clk_vga or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt     <= '0;
            h_sub     <= '0;
            win_x_cnt <= '0;
        end else if (line_end) begin
            h_cnt     <= '0;
            h_sub     <= '0;
            win_x_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
            if (h_sub == SUB_LAST) begin
                h_sub <= '0;
                // Hold at column 319 through the blank
                if (h_cnt < scan_cnt_t'(`FB_H_ACTIVE - 1))
                    win_x_cnt <= win_x_cnt + 1'b1;
            end else begin
                h_sub <= h_sub + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_vga or negedge rst_n) begin
        if (!rst_n) begin
            v_cnt     <= '0;
            v_sub     <= '0;
            win_y_cnt <= '0;
        end else if (frame_last) begin
            v_cnt     <= '0;          // Back to top line
            v_sub     <= '0;
            win_y_cnt <= '0;
        end else if (line_end) begin
            v_cnt <= v_cnt + 1'b1;
            if (v_sub == SUB_LAST) begin
                v_sub <= '0;
                if (v_cnt < scan_cnt_t'(`FB_V_ACTIVE - 1))
                    win_y_cnt <= win_y_cnt + 1'b1;   // Row 239 held in vblank
            end else begin
                v_sub <= v_sub + 1'b1;
            end
        end
    end

    // -----------------------------------------------------------------
    // Registered scan outputs, one cycle behind the counters
    // -----------------------------------------------------------------
    always_ff @(posedge clk_vga or negedge rst_n) begin
        if (!rst_n) begin
            scan.win_x <= '0;
            scan.win_y <= '0;
            scan.hsync <= 1'b1;       // Negative sync idles high
            scan.vsync <= 1'b1;
            scan.blank <= 1'b1;
            frame_end  <= 1'b0;
        end else begin
            scan.win_x <= win_x_cnt;
            scan.win_y <= win_y_cnt;
            scan.hsync <= !((h_cnt >= scan_cnt_t'(`FB_H_SYNC_START)) &&
                            (h_cnt <  scan_cnt_t'(`FB_H_SYNC_END)));
            scan.vsync <= !((v_cnt >= scan_cnt_t'(`FB_V_SYNC_START)) &&
                            (v_cnt <  scan_cnt_t'(`FB_V_SYNC_END)));
            scan.blank <= (h_cnt >= scan_cnt_t'(`FB_H_ACTIVE)) ||
                          (v_cnt >= scan_cnt_t'(`FB_V_ACTIVE));
            frame_end  <= frame_last; // Last pixel of line 524
        end
    end

    // Sync pulse only inside horizontal blank
    a_hsync_in_blank: assert property (@(posedge clk_vga) disable iff (!rst_n)
        !scan.hsync |-> ($past(h_cnt) >= scan_cnt_t'(`FB_H_ACTIVE)));

endmodule

//--- hdl/scan_if.sv
/*
 * Scan position bundle
 * Source window coordinate under the beam plus sync and blank levels
 */
interface scan_if;
    import fb_pkg::*;

    src_x_t win_x;    // Scan column / FB_SCALE
    src_y_t win_y;    // Scan line / FB_SCALE
    logic   hsync;    // Active low
    logic   vsync;    // Active low
    logic   blank;    // High outside 640x480

    // Timing generator side
    modport source (
        output win_x, win_y, hsync, vsync, blank
    );

    // Memory read and output stage side
    modport sink (
        input win_x, win_y, hsync, vsync, blank
    );

endinterface

//--- hdl/fb_pkg.sv
/*
 * Framebuffer types
 *   Pixel word, memory address and coordinates
 *   Scan counter, rotation mode
 *   Buffer state and buffer index
 */
package fb_pkg;

    typedef logic [7:0]  pixel_t;     // Colour word
    typedef logic [16:0] fb_addr_t;   // Covers 320*240 = 76800 words

    typedef logic [8:0]  src_x_t;     // Source column 0..319
    typedef logic [7:0]  src_y_t;     // Source row 0..239

    typedef logic [9:0]  scan_cnt_t;  // Output pixel or line count

    // Screen rotation
    typedef enum logic {
        ROT_0   = 1'b0,
        ROT_180 = 1'b1
    } rotate_t;

    // Life cycle of one frame buffer
    typedef enum logic [1:0] {
        BUF_FREE    = 2'd0,   // Holds nothing useful
        BUF_WRITING = 2'd1,   // Source frame going in
        BUF_READY   = 2'd2,   // Complete frame, waiting for display
        BUF_SHOWING = 2'd3    // Being scanned out
    } buf_state_t;

    typedef logic buf_sel_t;          // Buffer 0 or 1

endpackage

//--- hdl/fb_consts.svh
/*
 * Fixed constants of the framebuffer
 *   Source image size
 *   640x480@60 modeline numbers
 *   Output scale factor and read pipeline depth
 */
`ifndef FB_CONSTS_SVH
`define FB_CONSTS_SVH

// ---------------------------------------------------------------------
// Source image
// ---------------------------------------------------------------------
`define FB_SRC_W         (320)   // Source pixels per line
`define FB_SRC_H         (240)   // Source lines per frame

// ---------------------------------------------------------------------
// VGA 640x480@60 with negative syncs
// ---------------------------------------------------------------------
`define FB_H_ACTIVE      (640)   // Visible pixels
`define FB_H_SYNC_START  (656)   // First pixel of hsync pulse
`define FB_H_SYNC_END    (752)   // First pixel after hsync pulse
`define FB_H_TOTAL       (800)   // Pixels per line

`define FB_V_ACTIVE      (480)   // Visible lines
`define FB_V_SYNC_START  (490)   // First line of vsync pulse
`define FB_V_SYNC_END    (492)   // First line after vsync pulse
`define FB_V_TOTAL       (525)   // Lines per frame

// Each source pixel covers FB_SCALE x FB_SCALE output pixels
`define FB_SCALE         (2)

// Window coordinates to aligned output data
`define FB_RD_LATENCY    (2)

`endif
